/* tb.f */
common/core_params_pkg.sv
common/rob_types_pkg.sv
common/rob_entry_if.sv
rob/rob_entry.sv
rob/rob_control.sv
hdl/retire_rat.sv
hdl/rob_top.sv
testbench/clock_gen.sv
testbench/rob_sva.sv
testbench/tb_rob.sv

/* Makefile */
# Verilator build and run of the reorder buffer testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ^Result: PASSED$$

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_rob.sv */
//------------------------------------------------------------
// testbench for the reorder buffer top level
// a program order queue and a shadow rename table stand in
// for front end, execution units and free list
// inputs change 1 ns after the rising edge and outputs are
// read there, the dispatch tags later since they follow inputs
//------------------------------------------------------------
`timescale 1ns/1ns

module tb_rob
	import core_params_pkg::*, rob_types_pkg::*;
	();

	localparam int DRIVE_DELAY  = 1;                                 // ns after the rising edge
	localparam int SETTLE_DELAY = 10;                                // tags follow the valid strobes
	localparam int TEST_CYCLES  = 300 + 200 + 300 + 200;             // stimulus cycles of all tests
	localparam int CYCLE_LIMIT  = 4 * (2 * TEST_CYCLES) + 200;       // two dispatches per cycle at most

	typedef struct packed {
		rob_record_t           rec;
		logic [ROB_TAG_W-1:0]  tag;
		logic                  executed;
		logic                  mispredict;
		logic [PC_W-1:0]       target;
	} model_entry_t;

	logic                  clock;
	logic                  reset;
	logic                  d_valid0;
	logic                  d_valid1;
	rob_record_t           d_rec0;
	rob_record_t           d_rec1;
	logic                  c_valid;
	logic [ROB_TAG_W-1:0]  c_tag;
	logic                  c_mispredict;
	logic [PC_W-1:0]       c_target;
	logic                  dispatch_ready;
	logic [ROB_TAG_W-1:0]  dispatch_tag0;
	logic [ROB_TAG_W-1:0]  dispatch_tag1;
	logic                  commit_valid;
	commit_kind_e          commit_kind;
	logic [PC_W-1:0]       commit_pc;
	logic [ARN_W-1:0]      commit_arn;
	logic [PRN_W-1:0]      commit_prn;
	logic                  freed_valid;
	logic [PRN_W-1:0]      freed_prn;
	logic                  flush;
	logic [PC_W-1:0]       flush_pc;
	logic                  halted;

	model_entry_t          model_q [$];                 // live instructions, oldest first
	logic [PRN_W-1:0]      shadow_rat [ARCH_REGS];      // committed mapping as the model sees it
	logic [ROB_TAG_W-1:0]  model_tail;
	logic                  model_halted;
	logic                  saw_full;                    // occupancy went above depth minus two
	int                    errors = 0;
	int                    checks = 0;
	int                    n_commits = 0;
	int                    n_dispatched = 0;
	int                    tests_failed = 0;
	int                    cycle_count = 0;

	clock_gen u_clock_gen (.clock, .reset);

	rob_top u_dut (
		.clock, .reset,
		.dispatch_valid0(d_valid0), .dispatch_pc0(d_rec0.pc), .dispatch_arn0(d_rec0.arn),
		.dispatch_prn0(d_rec0.prn), .dispatch_is_branch0(d_rec0.is_branch),
		.dispatch_is_uncond0(d_rec0.is_uncond_branch), .dispatch_halt0(d_rec0.halt),
		.dispatch_illegal0(d_rec0.illegal),
		.dispatch_valid1(d_valid1), .dispatch_pc1(d_rec1.pc), .dispatch_arn1(d_rec1.arn),
		.dispatch_prn1(d_rec1.prn), .dispatch_is_branch1(d_rec1.is_branch),
		.dispatch_is_uncond1(d_rec1.is_uncond_branch), .dispatch_halt1(d_rec1.halt),
		.dispatch_illegal1(d_rec1.illegal),
		.complete_valid(c_valid), .complete_tag(c_tag),
		.complete_mispredict(c_mispredict), .complete_target(c_target),
		.dispatch_ready, .dispatch_tag0, .dispatch_tag1,
		.commit_valid, .commit_kind, .commit_pc, .commit_arn, .commit_prn,
		.freed_valid, .freed_prn, .flush, .flush_pc, .halted
	);

	function automatic rob_record_t random_record(input bit allow_halt);
		rob_record_t r;
		int unsigned roll;
		r = '0;
		r.pc  = {$urandom, $urandom};
		r.arn = ARN_W'($urandom_range(0, ARCH_REGS - 1));
		r.prn = PRN_W'($urandom_range(0, PRF_SIZE - 1));
		roll  = $urandom_range(0, 99);
		if (roll < 15)
			r.is_branch = 1'b1;
		else if (roll < 20)
			r.is_uncond_branch = 1'b1;
		else if (allow_halt && roll < 23)
			r.halt = 1'b1;
		else if (allow_halt && roll < 25)
			r.illegal = 1'b1;
		else if (roll < 35)
			r.arn = ARN_W'(NO_DEST_ARN);    // some writes have no destination
		return r;
	endfunction

	// retirement class by priority, a flag set wins over the ones below it
	function automatic commit_kind_e commit_class(input model_entry_t e);
		if (e.rec.halt)
			return KIND_HALT;
		if (e.rec.illegal)
			return KIND_ILLEGAL;
		if ((e.rec.is_branch || e.rec.is_uncond_branch) && e.mispredict)
			return KIND_MISPREDICT;
		if (e.rec.is_branch || e.rec.is_uncond_branch)
			return KIND_BRANCH;
		return KIND_NORMAL;
	endfunction

	// the fields that the top level shows at commit, flags left at zero
	function automatic rob_record_t commit_view(input logic [PC_W-1:0] pc,
		input logic [ARN_W-1:0] arn, input logic [PRN_W-1:0] prn);
		rob_record_t r;
		r     = '0;
		r.pc  = pc;
		r.arn = arn;
		r.prn = prn;
		return r;
	endfunction

	function automatic void push_entry(input rob_record_t r);
		model_entry_t e;
		e          = '0;
		e.rec      = r;
		e.tag      = model_tail;
		e.executed = r.halt | r.illegal;    // nothing for execution to report on these
		model_q.push_back(e);
		model_tail = model_tail + 1'b1;
		n_dispatched++;
	endfunction

	task automatic report_mismatch(input string what, input string got, input string exp);
		errors++;
		$display("mismatch at %0t: %s got %s expected %s", $time, what, got, exp);
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp)
			report_mismatch(what, $sformatf("%b", got), $sformatf("%b", exp));
	endtask

	task automatic check_tag(input string what, input logic [ROB_TAG_W-1:0] got,
		input logic [ROB_TAG_W-1:0] exp);
		checks++;
		if (got !== exp)
			report_mismatch(what, $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic check_commit(input rob_record_t got, input rob_record_t exp,
		input commit_kind_e got_kind, input commit_kind_e exp_kind);
		checks++;
		if (got !== exp || got_kind !== exp_kind)
			report_mismatch("commit", $sformatf("%h %s", got, got_kind.name()),
				$sformatf("%h %s", exp, exp_kind.name()));
	endtask

	task automatic check_freed(input logic [PRN_W-1:0] got, input logic [PRN_W-1:0] exp);
		checks++;
		if (got !== exp)
			report_mismatch("freed_prn", $sformatf("%0d", got), $sformatf("%0d", exp));
	endtask

	task automatic check_flush(input logic [PC_W-1:0] got, input logic [PC_W-1:0] exp);
		checks++;
		if (got !== exp)
			report_mismatch("flush_pc", $sformatf("%h", got), $sformatf("%h", exp));
	endtask

	// one clock cycle: check the outputs, update the model, drive the next inputs
	task automatic run_cycle(input int max_disp, input int complete_pct,
		input int mispredict_pct, input bit allow_halt);
		model_entry_t          head;
		model_entry_t          ent;
		commit_kind_e          exp_kind;
		logic                  exp_commit;
		logic                  exp_flush;
		logic                  exp_ready;
		logic [ROB_TAG_W-1:0]  exp_tag0;
		logic [ROB_TAG_W-1:0]  exp_tag1;
		int                    n;
		int                    pick;
		int                    pending [$];
		@(posedge clock);
		#DRIVE_DELAY;
		head       = '0;
		exp_kind   = KIND_NORMAL;
		exp_commit = (model_q.size() > 0) && !model_halted;
		if (exp_commit)
		begin
			head       = model_q[0];
			exp_commit = head.executed;    // head waits for its completion
			exp_kind   = commit_class(head);
		end
		exp_flush = exp_commit && (exp_kind == KIND_MISPREDICT);
		exp_ready = (model_q.size() <= ROB_DEPTH - 2) && !exp_flush && !model_halted;
		if (model_q.size() > ROB_DEPTH - 2)
			saw_full = 1'b1;
		check_flag("commit_valid", commit_valid, exp_commit);
		check_flag("flush", flush, exp_flush);
		check_flag("dispatch_ready", dispatch_ready, exp_ready);
		check_flag("halted", halted, model_halted);
		check_flag("freed_valid", freed_valid, exp_commit && head.rec.arn != ARN_W'(NO_DEST_ARN));
		if (exp_commit)
		begin
			check_commit(commit_view(commit_pc, commit_arn, commit_prn),
				commit_view(head.rec.pc, head.rec.arn, head.rec.prn), commit_kind, exp_kind);
			if (head.rec.arn != ARN_W'(NO_DEST_ARN))
			begin
				check_freed(freed_prn, shadow_rat[head.rec.arn]);
				shadow_rat[head.rec.arn] = head.rec.prn;
			end
			if (exp_flush)
				check_flush(flush_pc, head.target);
			if (head.rec.halt || head.rec.illegal)
				model_halted = 1'b1;    // takes effect from the next cycle
			void'(model_q.pop_front());
			n_commits++;
		end
		d_valid0 = 1'b0;
		d_valid1 = 1'b0;
		c_valid  = 1'b0;
		// completion first, a slot dispatched in this cycle is not live yet
		if (!exp_flush && $urandom_range(0, 99) < complete_pct)
		begin
			foreach (model_q[i])
				if (!model_q[i].executed)
					pending.push_back(i);
			if (pending.size() > 0)
			begin
				pick           = pending[$urandom_range(0, pending.size() - 1)];
				ent            = model_q[pick];
				ent.executed   = 1'b1;
				ent.target     = {$urandom, $urandom};
				ent.mispredict = (ent.rec.is_branch || ent.rec.is_uncond_branch) &&
					($urandom_range(0, 99) < mispredict_pct);
				model_q[pick]  = ent;
				c_valid        = 1'b1;
				c_tag          = ent.tag;
				c_mispredict   = ent.mispredict;
				c_target       = ent.target;
			end
		end
		exp_tag0 = model_tail;
		exp_tag1 = model_tail;
		if (exp_ready)
		begin
			n      = $urandom_range(0, max_disp);
			d_rec0 = random_record(allow_halt);
			d_rec1 = random_record(allow_halt);
			if (n == 2)
			begin
				d_valid0 = 1'b1;
				d_valid1 = 1'b1;
			end
			else if (n == 1)
			begin
				if ($urandom_range(0, 1) == 0)
					d_valid0 = 1'b1;
				else
					d_valid1 = 1'b1;    // slot 1 alone takes the tail itself
			end
			if (d_valid0)
				exp_tag1 = model_tail + 1'b1;
			if (d_valid0)
				push_entry(d_rec0);
			if (d_valid1)
				push_entry(d_rec1);
		end
		#SETTLE_DELAY;
		check_tag("dispatch_tag0", dispatch_tag0, exp_tag0);
		check_tag("dispatch_tag1", dispatch_tag1, exp_tag1);
		if (exp_flush)
		begin
			model_q.delete();    // everything younger was on the wrong path
			model_tail = '0;
		end
	endtask

	task automatic run_test(input string name, input int cycles, input int max_disp,
		input int complete_pct, input int mispredict_pct, input bit allow_halt,
		input bit need_full);
		int err0;
		int com0;
		err0     = errors;
		com0     = n_commits;
		saw_full = 1'b0;
		repeat (cycles)
			run_cycle(max_disp, complete_pct, mispredict_pct, allow_halt);
		while (!model_halted && model_q.size() != 0)    // drain so nothing is left behind
			run_cycle(0, 100, mispredict_pct, 1'b0);
		if (allow_halt && !model_halted)
		begin
			errors++;
			$display("%s: no halt or illegal instruction ever committed", name);
		end
		if (need_full && !saw_full)
		begin
			errors++;
			$display("%s: the buffer never filled up", name);
		end
		if (errors != err0)
			tests_failed++;
		$display("test %-16s %0d commits, %0d errors", name, n_commits - com0, errors - err0);
	endtask

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	initial
	begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h93271d5d));
		d_valid0     = 1'b0;
		d_valid1     = 1'b0;
		d_rec0       = '0;
		d_rec1       = '0;
		c_valid      = 1'b0;
		c_tag        = '0;
		c_mispredict = 1'b0;
		c_target     = '0;
		model_tail   = '0;
		model_halted = 1'b0;
		saw_full     = 1'b0;
		for (int i = 0; i < ARCH_REGS; i++)
			shadow_rat[i] = PRN_W'(i);    // identity mapping out of reset
		@(negedge reset);
		run_test("in_order_commit", 300, 2, 100, 0, 1'b0, 1'b0);
		run_test("full_buffer", 200, 2, 30, 0, 1'b0, 1'b1);
		run_test("mispredict", 300, 2, 90, 30, 1'b0, 1'b0);
		run_test("halt_stop", 200, 2, 100, 0, 1'b1, 1'b0);
		errors = errors + int'(u_dut.u_control.u_sva.fail_count);
		$display("tests 4, failed %0d, checks %0d, errors %0d, dispatched %0d, committed %0d",
			tests_failed, checks, errors, n_dispatched, n_commits);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* testbench/rob_sva.sv */
//------------------------------------------------------------
// assertions on the commit control of the reorder buffer
// bound into every rob_control, inactive during reset
// fail_count lets the testbench see a failed property
//------------------------------------------------------------
`timescale 1ns/1ns

module rob_sva
	import core_params_pkg::*, rob_types_pkg::*;
(
	input logic                  clock,
	input logic                  reset,
	input logic [ROB_CNT_W-1:0]  count,
	input rob_state_e            state,
	input logic                  commit_valid,
	input logic                  flush
);

	int unsigned fail_count = 0;    // number of failed properties so far

	a_count_bound: assert property (@(posedge clock) disable iff (reset)
		count <= ROB_CNT_W'(ROB_DEPTH))
	else
	begin
		fail_count++;
		$error("occupancy %0d is above the buffer depth", count);
	end

	a_commit_live: assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> (count != '0))
	else
	begin
		fail_count++;
		$error("commit raised while the occupancy is zero");    // head slot and count disagree
	end

	a_halted_frozen: assert property (@(posedge clock) disable iff (reset)
		(state == ST_HALTED) |=> ((state == ST_HALTED) && $stable(count)))
	else
	begin
		fail_count++;
		$error("buffer changed or left the halted state before reset");
	end

	a_flush_empties: assert property (@(posedge clock) disable iff (reset)
		flush |=> (count == '0))
	else
	begin
		fail_count++;
		$error("buffer not empty after a flush");
	end

endmodule

bind rob_control rob_sva u_sva (
	.clock, .reset, .count, .state, .commit_valid, .flush
);

/* testbench/clock_gen.sv */
//------------------------------------------------------------
// clock and reset for the reorder buffer testbench
// 100 ns period, reset high for the first 10 rising edges
// reset drops 1 ns after an edge, like the other inputs
//------------------------------------------------------------
`timescale 1ns/1ns

module clock_gen
(
	output logic clock,
	output logic reset
);

	localparam int HALF_PERIOD = 50;    // ns, gives the 100 ns period

	initial
	begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;    // first active edge is the eleventh one
	end

endmodule

/* hdl/rob_top.sv */
//------------------------------------------------------------
// reorder buffer top level with the retirement rename table
// two dispatch slots in program order, slot 0 is older
// one completion and one commit per cycle
// free list, front end and execution units are outside
//------------------------------------------------------------
`timescale 1ns/1ns

module rob_top
	import core_params_pkg::*, rob_types_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch_valid0,
	input  logic [PC_W-1:0]       dispatch_pc0,
	input  logic [ARN_W-1:0]      dispatch_arn0,
	input  logic [PRN_W-1:0]      dispatch_prn0,
	input  logic                  dispatch_is_branch0,
	input  logic                  dispatch_is_uncond0,
	input  logic                  dispatch_halt0,
	input  logic                  dispatch_illegal0,
	input  logic                  dispatch_valid1,
	input  logic [PC_W-1:0]       dispatch_pc1,
	input  logic [ARN_W-1:0]      dispatch_arn1,
	input  logic [PRN_W-1:0]      dispatch_prn1,
	input  logic                  dispatch_is_branch1,
	input  logic                  dispatch_is_uncond1,
	input  logic                  dispatch_halt1,
	input  logic                  dispatch_illegal1,
	input  logic                  complete_valid,
	input  logic [ROB_TAG_W-1:0]  complete_tag,
	input  logic                  complete_mispredict,
	input  logic [PC_W-1:0]       complete_target,
	output logic                  dispatch_ready,
	output logic [ROB_TAG_W-1:0]  dispatch_tag0,
	output logic [ROB_TAG_W-1:0]  dispatch_tag1,
	output logic                  commit_valid,
	output commit_kind_e          commit_kind,
	output logic [PC_W-1:0]       commit_pc,
	output logic [ARN_W-1:0]      commit_arn,
	output logic [PRN_W-1:0]      commit_prn,
	output logic                  freed_valid,
	output logic [PRN_W-1:0]      freed_prn,
	output logic                  flush,
	output logic [PC_W-1:0]       flush_pc,
	output logic                  halted
);

	rob_record_t rec0;          // slot 0 fields packed into one record
	rob_record_t rec1;
	rob_record_t commit_rec;    // head record, valid with commit_valid

	assign rec0 = '{dispatch_pc0, dispatch_arn0, dispatch_prn0, dispatch_is_branch0,
		dispatch_is_uncond0, dispatch_halt0, dispatch_illegal0};
	assign rec1 = '{dispatch_pc1, dispatch_arn1, dispatch_prn1, dispatch_is_branch1,
		dispatch_is_uncond1, dispatch_halt1, dispatch_illegal1};

	assign commit_pc  = commit_rec.pc;
	assign commit_arn = commit_rec.arn;
	assign commit_prn = commit_rec.prn;

	rob_entry_if entry_bus [ROB_DEPTH] ();    // one bundle per slot

	rob_control u_control (
		.clock, .reset,
		.dispatch_valid0, .dispatch_rec0(rec0),
		.dispatch_valid1, .dispatch_rec1(rec1),
		.complete_valid, .complete_tag, .complete_mispredict, .complete_target,
		.entries(entry_bus),
		.dispatch_ready, .dispatch_tag0, .dispatch_tag1,
		.commit_valid, .commit_kind, .commit_rec,
		.flush, .flush_pc, .halted
	);

	for (genvar i = 0; i < ROB_DEPTH; i++)
	begin : g_entry
		rob_entry u_entry (
			.clock, .reset,
			.entry(entry_bus[i])
		);
	end

	retire_rat u_rat (
		.clock, .reset,
		.commit_valid, .commit_arn, .commit_prn,
		.freed_valid, .freed_prn
	);

endmodule

/* hdl/retire_rat.sv */
//------------------------------------------------------------
// retirement rename table, architected to physical mapping
// reset maps register i onto physical register i
// freed_prn is read in the commit cycle, the write lands at
// the next edge; NO_DEST_ARN is never written
//------------------------------------------------------------
`timescale 1ns/1ns

module retire_rat
	import core_params_pkg::*;
(
	input  logic              clock,
	input  logic              reset,
	input  logic              commit_valid,
	input  logic [ARN_W-1:0]  commit_arn,
	input  logic [PRN_W-1:0]  commit_prn,
	output logic              freed_valid,
	output logic [PRN_W-1:0]  freed_prn
);

	logic [PRN_W-1:0] map_q [ARCH_REGS];    // committed mapping per architected register

	// the old mapping goes back to the free list once the new write retires
	assign freed_valid = commit_valid && (commit_arn != ARN_W'(NO_DEST_ARN));
	assign freed_prn   = map_q[commit_arn];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < ARCH_REGS; i++)
				map_q[i] <= PRN_W'(i);    // identity mapping out of reset
		end
		else if (freed_valid)
			map_q[commit_arn] <= commit_prn;
	end

endmodule

/* rob/rob_control.sv */
//------------------------------------------------------------
// head, tail and occupancy of the reorder buffer
// dispatch strobes while dispatch_ready is low are illegal
// completion tags must name a live slot that has not executed
// commit is one per cycle from the head, no back-pressure
// a halt or illegal commit stops the machine until reset
//------------------------------------------------------------
`timescale 1ns/1ns

module rob_control
	import core_params_pkg::*, rob_types_pkg::*;
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  dispatch_valid0,         // older dispatch slot
	input  rob_record_t           dispatch_rec0,
	input  logic                  dispatch_valid1,         // younger dispatch slot
	input  rob_record_t           dispatch_rec1,
	input  logic                  complete_valid,
	input  logic [ROB_TAG_W-1:0]  complete_tag,
	input  logic                  complete_mispredict,
	input  logic [PC_W-1:0]       complete_target,
	rob_entry_if.control          entries [ROB_DEPTH],
	output logic                  dispatch_ready,
	output logic [ROB_TAG_W-1:0]  dispatch_tag0,
	output logic [ROB_TAG_W-1:0]  dispatch_tag1,
	output logic                  commit_valid,
	output commit_kind_e          commit_kind,
	output rob_record_t           commit_rec,
	output logic                  flush,
	output logic [PC_W-1:0]       flush_pc,
	output logic                  halted
);

	logic [ROB_TAG_W-1:0]  head;                    // oldest live slot
	logic [ROB_TAG_W-1:0]  tail;                    // next free slot
	logic [ROB_CNT_W-1:0]  count;                   // live slots
	rob_state_e            state;
	logic                  take0;                   // slot 0 accepted this cycle
	logic                  take1;                   // slot 1 accepted this cycle
	logic [1:0]            n_disp;                  // instructions entering this cycle
	logic                  in_use_vec   [ROB_DEPTH];
	logic                  executed_vec [ROB_DEPTH];
	logic                  mispred_vec  [ROB_DEPTH];
	rob_record_t           rec_arr      [ROB_DEPTH];
	logic [PC_W-1:0]       target_arr   [ROB_DEPTH];
	rob_record_t           head_rec;

	// two free slots are needed since a pair may arrive at any time
	assign dispatch_ready = (count <= ROB_CNT_W'(ROB_DEPTH - 2)) && !flush && (state == ST_RUNNING);
	assign take0          = dispatch_valid0 && dispatch_ready;
	assign take1          = dispatch_valid1 && dispatch_ready;
	assign n_disp         = 2'(take0) + 2'(take1);
	assign dispatch_tag0  = tail;
	assign dispatch_tag1  = dispatch_valid0 ? tail + 1'b1 : tail;    // slot 1 packs behind slot 0

	// per-slot steering and gathering of the slot state
	for (genvar i = 0; i < ROB_DEPTH; i++)
	begin : g_slot
		logic hit0;    // slot 0 lands here
		logic hit1;    // slot 1 lands here
		assign hit0 = take0 && (dispatch_tag0 == ROB_TAG_W'(i));
		assign hit1 = take1 && (dispatch_tag1 == ROB_TAG_W'(i));
		assign entries[i].load                = hit0 || hit1;
		assign entries[i].load_rec            = hit0 ? dispatch_rec0 : dispatch_rec1;
		assign entries[i].complete            = complete_valid && !flush && (complete_tag == ROB_TAG_W'(i));
		assign entries[i].complete_mispredict = complete_mispredict;
		assign entries[i].complete_target     = complete_target;
		assign entries[i].retire              = commit_valid && (head == ROB_TAG_W'(i));
		assign entries[i].flush               = flush;
		assign in_use_vec[i]   = entries[i].in_use;
		assign executed_vec[i] = entries[i].executed;
		assign mispred_vec[i]  = entries[i].mispredict;
		assign rec_arr[i]      = entries[i].rec;
		assign target_arr[i]   = entries[i].target;
	end

	// commit decision on the head slot
	assign head_rec     = rec_arr[head];
	assign commit_rec   = head_rec;
	assign commit_valid = in_use_vec[head] && executed_vec[head] && (state == ST_RUNNING);

	always_comb
	begin
		if (head_rec.halt)
			commit_kind = KIND_HALT;
		else if (head_rec.illegal)
			commit_kind = KIND_ILLEGAL;
		else if ((head_rec.is_branch || head_rec.is_uncond_branch) && mispred_vec[head])
			commit_kind = KIND_MISPREDICT;    // wrong path behind it must go
		else if (head_rec.is_branch || head_rec.is_uncond_branch)
			commit_kind = KIND_BRANCH;
		else
			commit_kind = KIND_NORMAL;
	end

	assign flush    = commit_valid && (commit_kind == KIND_MISPREDICT);
	assign flush_pc = target_arr[head];    // front end restarts here
	assign halted   = (state == ST_HALTED);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			state <= ST_RUNNING;
		end
		else if (flush)    // buffer is empty after this edge, dispatch here was blocked
		begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			head  <= head + ROB_TAG_W'(commit_valid);
			tail  <= tail + ROB_TAG_W'(n_disp);
			count <= count + ROB_CNT_W'(n_disp) - ROB_CNT_W'(commit_valid);
			if (commit_valid && (commit_kind == KIND_HALT || commit_kind == KIND_ILLEGAL))
				state <= ST_HALTED;    // sticky until reset
		end
	end

endmodule

/* rob/rob_entry.sv */
//------------------------------------------------------------
// one reorder buffer slot
// a single load port, rob_control picks which dispatch slot
// lands here; halt and illegal are executed on load
// a completion on a free slot is ignored
// stored record and target are not reset, read them only
// while in_use is high
//------------------------------------------------------------
`timescale 1ns/1ns

module rob_entry
	import core_params_pkg::*, rob_types_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	rob_entry_if.entry  entry
);

	logic              in_use_q;        // slot holds an instruction
	logic              executed_q;      // instruction has finished execution
	logic              mispredict_q;    // branch outcome disagreed with the prediction
	rob_record_t       rec_q;           // record captured at dispatch
	logic [PC_W-1:0]   target_q;        // branch target reported by execution

	// control state of the slot
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			in_use_q     <= 1'b0;
			executed_q   <= 1'b0;
			mispredict_q <= 1'b0;
		end
		else if (entry.flush)    // flush drops every slot at once
		begin
			in_use_q     <= 1'b0;
			executed_q   <= 1'b0;
			mispredict_q <= 1'b0;
		end
		else if (entry.load)
		begin
			in_use_q     <= 1'b1;
			executed_q   <= entry.load_rec.halt | entry.load_rec.illegal;    // nothing to execute for these
			mispredict_q <= 1'b0;
		end
		else if (entry.retire)    // head leaves the buffer
		begin
			in_use_q     <= 1'b0;
			executed_q   <= 1'b0;
			mispredict_q <= 1'b0;
		end
		else if (entry.complete && in_use_q)
		begin
			executed_q   <= 1'b1;
			mispredict_q <= entry.complete_mispredict;
		end
	end

	// payload, written only on load and on completion
	always_ff @(posedge clock)
	begin
		if (entry.load && !entry.flush)
			rec_q <= entry.load_rec;
		if (entry.complete && in_use_q && !entry.flush && !entry.load)
			target_q <= entry.complete_target;    // only meaningful for branches
	end

	// the slot always shows its contents, the control side picks the head
	assign entry.in_use     = in_use_q;
	assign entry.executed   = executed_q;
	assign entry.rec        = rec_q;
	assign entry.mispredict = mispredict_q;
	assign entry.target     = target_q;

endmodule

/* common/rob_entry_if.sv */
//------------------------------------------------------------
// signals between the buffer control and one slot
// one instance per slot, the control side owns all strobes
// load, retire and flush never target the same slot together
// except flush, which wins over everything in the slot
//------------------------------------------------------------
`timescale 1ns/1ns

interface rob_entry_if
	import core_params_pkg::*, rob_types_pkg::*;
	();

	// control to slot
	logic              load;                  // write load_rec into the slot
	rob_record_t       load_rec;              // record steered from dispatch slot 0 or 1
	logic              complete;              // execution finished for this slot
	logic              complete_mispredict;   // branch resolved against the prediction
	logic [PC_W-1:0]   complete_target;       // resolved branch target
	logic              retire;                // slot is the committing head
	logic              flush;                 // whole buffer empties

	// slot to control
	logic              in_use;                // slot holds a live instruction
	logic              executed;              // result ready, slot may commit
	rob_record_t       rec;                   // stored record, always readable
	logic              mispredict;            // stored mispredict flag
	logic [PC_W-1:0]   target;                // stored branch target

	modport control (
		output load, load_rec, complete, complete_mispredict, complete_target,
		output retire, flush,
		input  in_use, executed, rec, mispredict, target
	);

	modport entry (
		input  load, load_rec, complete, complete_mispredict, complete_target,
		input  retire, flush,
		output in_use, executed, rec, mispredict, target
	);

endinterface

/* common/rob_types_pkg.sv */
//------------------------------------------------------------
// record and enum types of the reorder buffer
// shared by the RTL and the testbench
// the record holds only what commit needs, no operand values
//------------------------------------------------------------
package rob_types_pkg;

	import core_params_pkg::*;

	// one dispatched instruction as it sits in a slot, about 80 bits
	typedef struct packed {
		logic [PC_W-1:0]  pc;                  // pc of the instruction
		logic [ARN_W-1:0] arn;                 // architected destination
		logic [PRN_W-1:0] prn;                 // physical destination from rename
		logic             is_branch;           // conditional branch
		logic             is_uncond_branch;    // jump or call
		logic             halt;                // halt, executes on dispatch
		logic             illegal;             // illegal opcode, also executes on dispatch
	} rob_record_t;

	// class of the instruction that is being retired this cycle
	typedef enum logic [2:0] {
		KIND_NORMAL     = 3'd0,
		KIND_BRANCH     = 3'd1,    // branch that was predicted right
		KIND_MISPREDICT = 3'd2,    // branch that raises a flush
		KIND_HALT       = 3'd3,
		KIND_ILLEGAL    = 3'd4
	} commit_kind_e;

	// commit control state, halted holds until reset
	typedef enum logic {
		ST_RUNNING = 1'b0,
		ST_HALTED  = 1'b1
	} rob_state_e;

endpackage

/* common/core_params_pkg.sv */
//------------------------------------------------------------
// machine sizes of the two-wide core
// ROB_DEPTH must be a power of two, the buffer pointers wrap
// by overflow and carry no extra wrap bit
// architected register NO_DEST_ARN marks "no destination"
//------------------------------------------------------------
package core_params_pkg;

	localparam int ARCH_REGS   = 32;                    // architected integer registers
	localparam int NO_DEST_ARN = 31;                    // destination that is never renamed
	localparam int PRF_SIZE    = 64;                    // physical register file entries
	localparam int ROB_DEPTH   = 16;                    // reorder buffer slots
	localparam int PC_W        = 64;                    // program counter width

	// derived widths, keep these tied to the sizes above
	localparam int ARN_W       = $clog2(ARCH_REGS);     // architected register number
	localparam int PRN_W       = $clog2(PRF_SIZE);      // physical register number
	localparam int ROB_TAG_W   = $clog2(ROB_DEPTH);     // buffer slot index
	localparam int ROB_CNT_W   = ROB_TAG_W + 1;         // occupancy, must reach ROB_DEPTH

endpackage
